// File: debugLink.f
+incdir+include
design/debugLinkPkg.sv
design/byteFifo.sv
design/serialReceiver.sv
design/commandHandler.sv
design/messageFramer.sv
design/serialTransmitter.sv
design/debugLinkTop.sv
tb/debugLinkTb.sv

// File: Bender.yml
package:
  name: debugLink

export_include_dirs:
  - include

sources:
  # Design sources in compile order
  - include_dirs:
      - include
    files:
      - design/debugLinkPkg.sv
      - design/byteFifo.sv
      - design/serialReceiver.sv
      - design/commandHandler.sv
      - design/messageFramer.sv
      - design/serialTransmitter.sv
      - design/debugLinkTop.sv
  # Testbench
  - target: test
    include_dirs:
      - include
    files:
      - tb/debugLinkTb.sv

// File: tb/debugLink_cases.txt
# name command(hex) ledBit length payload0(hex) payload1(hex) chain
# chain 1 sends the next command before this reply is read; length 0 means no reply
ledOn 81 1 1 81 00 0
statusAfterOn 82 1 2 01 02 0
ledOff 80 0 1 80 00 0
nop 00 0 0 00 00 0
statusAfterNop 82 0 2 00 04 0
unknownByte 47 0 1 FF 00 0
statusAfterUnknown 82 0 2 00 06 0
nopTwice 00 0 0 00 00 0
burstLedOn 81 1 1 81 00 1
burstStatusOn 82 1 2 01 08 1
burstUnknown 55 1 1 FF 00 1
burstLedOff 80 0 1 80 00 1
burstStatusOff 82 0 2 00 0B 0
unknownHigh A5 0 1 FF 00 0
finalStatus 82 0 2 00 0D 0

// File: tb/debugLinkTb.sv
`timescale 1ns/1ns

module debugLinkTb;

    localparam int MaxCases = 64;
    // Zero bytes tolerated before a length byte
    localparam int ReplySearchBytes = 8;
    // Bytes watched for silence after a Nop
    localparam int NopWindowBytes = 6;

    logic                      clk;
    logic                      rst;
    debugLinkPkg::serialPins_t pins;
    logic                      debugDo;
    logic [3:0]                led;

    // Case table
    string      caseName [MaxCases];
    logic [7:0] caseCmd [MaxCases];
    int         caseLed [MaxCases];
    int         caseLen [MaxCases];
    logic [7:0] casePay0 [MaxCases];
    logic [7:0] casePay1 [MaxCases];
    int         caseChain [MaxCases];
    int         numCases;

    // Bytes seen on debugDo and not yet parsed
    logic [7:0] rxQueue [$];
    int         errorCount;
    int         timeoutCount;
    longint     cycleCount;
    longint     timeoutLimit;

    debugLinkTop debugLinkTop_i (
        .clk(clk), .rst(rst), .pins(pins), .debugDo(debugDo), .led(led)
    );

    always #50 clk = ~clk;

    // ==================================================================
    // Cycle limit
    // ==================================================================
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (timeoutLimit != 0 && cycleCount >= timeoutLimit) begin
            timeoutCount = timeoutCount + 1;
            $display("Timeout: run still busy after %0d clock cycles", cycleCount);
            $display("Errors: %0d, timeouts: %0d", errorCount, timeoutCount);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic loadCases();
        int         fd;
        int         fields;
        string      line;
        string      name;
        logic [7:0] cmd;
        logic [7:0] p0;
        logic [7:0] p1;
        int         ledBit;
        int         len;
        int         chain;
        fd = $fopen("tb/debugLink_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the case file tb/debugLink_cases.txt");
            errorCount++;
            return;
        end
        while ($fgets(line, fd) != 0 && numCases < MaxCases) begin
            fields = $sscanf(line, "%s %h %d %d %h %h %d",
                             name, cmd, ledBit, len, p0, p1, chain);
            // Comment lines and blank lines are skipped
            if (fields == 7 && line.getc(0) != "#") begin
                caseName[numCases]  = name;
                caseCmd[numCases]   = cmd;
                caseLed[numCases]   = ledBit;
                caseLen[numCases]   = len;
                casePay0[numCases]  = p0;
                casePay1[numCases]  = p1;
                caseChain[numCases] = chain;
                numCases++;
            end
        end
        $fclose(fd);
    endtask

    // ==================================================================
    // Host model shifting one byte out on debugDi and one byte in from debugDo
    // ==================================================================
    task automatic transferByte(input logic [7:0] txByte);
        logic [7:0] rxByte;
        rxByte = 8'h00;
        for (int i = 7; i >= 0; i--) begin
            pins.debugDi = txByte[i];
            repeat (8) @(negedge clk);
            pins.debugClk = 1'b1;
            repeat (8) @(negedge clk);
            // Sampled at the falling debugClk edge
            rxByte[i] = debugDo;
            pins.debugClk = 1'b0;
        end
        rxQueue.push_back(rxByte);
    endtask

    // Idle bytes are shifted only when nothing is buffered
    task automatic receiveByte(output logic [7:0] value);
        if (rxQueue.size() == 0) transferByte(8'h00);
        value = rxQueue.pop_front();
    endtask

    task automatic checkReply(input int idx);
        logic [7:0] value;
        int         seen;
        value = 8'h00;
        seen = 0;
        if (caseLen[idx] == 0) begin
            while (seen < NopWindowBytes && value == 8'h00) begin
                receiveByte(value);
                seen++;
            end
            if (value != 8'h00) begin
                $display("ERROR %s: reply expected 0x00, actual 0x%02h", caseName[idx], value);
                errorCount++;
            end
            return;
        end
        receiveByte(value);
        while (value == 8'h00 && seen < ReplySearchBytes) begin
            seen++;
            receiveByte(value);
        end
        if (value == 8'h00) begin
            $display("Case %s: no reply arrived within %0d bytes", caseName[idx], seen);
            errorCount++;
            return;
        end
        if (value !== 8'(caseLen[idx])) begin
            $display("ERROR %s: length expected %0d, actual %0d",
                     caseName[idx], caseLen[idx], value);
            errorCount++;
        end
        receiveByte(value);
        if (value !== casePay0[idx]) begin
            $display("ERROR %s: payload0 expected 0x%02h, actual 0x%02h",
                     caseName[idx], casePay0[idx], value);
            errorCount++;
        end
        if (caseLen[idx] == 2) begin
            receiveByte(value);
            if (value !== casePay1[idx]) begin
                $display("ERROR %s: payload1 expected 0x%02h, actual 0x%02h",
                         caseName[idx], casePay1[idx], value);
                errorCount++;
            end
        end
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial begin
        int first;
        int last;
        clk = 1'b0;
        rst = 1'b1;
        pins = '0;
        errorCount = 0;
        timeoutCount = 0;
        cycleCount = 0;
        timeoutLimit = 0;
        numCases = 0;
        loadCases();
        timeoutLimit = longint'(numCases) * 20 * 8 * 16;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (led !== 4'h0) begin
            $display("ERROR reset: led expected 0x0, actual 0x%0h", led);
            errorCount++;
        end
        if (debugDo !== 1'b0) begin
            $display("ERROR reset: debugDo expected 0, actual %b", debugDo);
            errorCount++;
        end
        pins.debugCs = 1'b1;
        repeat (8) @(negedge clk);
        if (numCases == 0) begin
            $display("No cases were read from the case file");
            errorCount++;
        end
        first = 0;
        while (first < numCases) begin
            // A chained group goes out back to back
            last = first;
            while (caseChain[last] != 0 && last + 1 < numCases) last++;
            for (int k = first; k <= last; k++) transferByte(caseCmd[k]);
            for (int k = first; k <= last; k++) checkReply(k);
            if (led[0] !== caseLed[last][0]) begin
                $display("ERROR %s: led bit expected %0d, actual %b",
                         caseName[last], caseLed[last], led[0]);
                errorCount++;
            end
            first = last + 1;
        end
        $display("Errors: %0d, timeouts: %0d", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: design/debugLinkTop.sv
`timescale 1ns/1ns
`include "debugLink_settings.svh"

module debugLinkTop (
    input  logic                      clk,
    input  logic                      rst,
    input  debugLinkPkg::serialPins_t pins,
    output logic                      debugDo,
    output logic [3:0]                led
);
    debugLinkPkg::serialEdge_t  pinEvent;
    logic [7:0]                 cmdData;
    logic                       cmdValid;
    logic [7:0]                 cmdOutData;
    logic                       cmdOutValid;
    logic                       cmdPop;
    debugLinkPkg::responseReq_t req;
    logic                       reqValid;
    logic                       reqReady;
    logic [7:0]                 respInData;
    logic                       respInValid;
    logic                       respInReady;
    logic [7:0]                 respData;
    logic                       respValid;
    logic                       respPop;

    // ==================================================================
    // Command path
    // ==================================================================
    serialReceiver receiver (
        .clk(clk), .rst(rst), .pins(pins), .pinEvent(pinEvent),
        .cmdData(cmdData), .cmdValid(cmdValid)
    );

    // Full queue drops the incoming byte
    byteFifo #(.Depth(`DEBUG_FIFO_DEPTH)) cmdQueue (
        .clk(clk), .rst(rst),
        .writeData(cmdData), .writeValid(cmdValid), .writeReady(),
        .readData(cmdOutData), .readValid(cmdOutValid), .readPop(cmdPop)
    );

    commandHandler handler (
        .clk(clk), .rst(rst),
        .cmdData(cmdOutData), .cmdValid(cmdOutValid), .cmdPop(cmdPop),
        .req(req), .reqValid(reqValid), .reqReady(reqReady), .led(led)
    );

    // ==================================================================
    // Response path
    // ==================================================================
    messageFramer framer (
        .clk(clk), .rst(rst),
        .req(req), .reqValid(reqValid), .reqReady(reqReady),
        .outData(respInData), .outValid(respInValid), .outReady(respInReady)
    );

    byteFifo #(.Depth(`DEBUG_FIFO_DEPTH)) respQueue (
        .clk(clk), .rst(rst),
        .writeData(respInData), .writeValid(respInValid), .writeReady(respInReady),
        .readData(respData), .readValid(respValid), .readPop(respPop)
    );

    serialTransmitter transmitter (
        .clk(clk), .rst(rst), .pinEvent(pinEvent),
        .respData(respData), .respValid(respValid), .respPop(respPop),
        .debugDo(debugDo)
    );

endmodule

// File: design/serialTransmitter.sv
`timescale 1ns/1ns

module serialTransmitter (
    input  logic                      clk,
    input  logic                      rst,
    input  debugLinkPkg::serialEdge_t pinEvent,
    input  logic [7:0]                respData,
    input  logic                      respValid,
    output logic                      respPop,
    output logic                      debugDo
);
    logic [7:0] shiftReg;
    logic       loadByte;

    // ==================================================================
    // Byte alignment comes from the receiver's edge flags
    // ==================================================================
    assign loadByte = pinEvent.rise && pinEvent.boundary;

    // Take the FIFO head only when there is one
    assign respPop = loadByte && respValid;

    // MSB first; host samples on the falling debugClk edge
    assign debugDo = shiftReg[7];

    always_ff @(posedge clk) begin
        if (rst) begin
            shiftReg <= '0;
        end else if (loadByte) begin
            // Idle slot sends zeros, which the host skips
            shiftReg <= respValid ? respData : 8'h00;
        end else if (pinEvent.rise) begin
            shiftReg <= {shiftReg[6:0], 1'b0};
        end
    end

endmodule

// File: design/messageFramer.sv
`timescale 1ns/1ns

module messageFramer (
    input  logic                       clk,
    input  logic                       rst,
    input  debugLinkPkg::responseReq_t req,
    input  logic                       reqValid,
    output logic                       reqReady,
    output logic [7:0]                 outData,
    output logic                       outValid,
    input  logic                       outReady
);
    // Byte being offered to the response FIFO
    localparam logic [1:0] SendLength   = 2'd0;
    localparam logic [1:0] SendPayload0 = 2'd1;
    localparam logic [1:0] SendPayload1 = 2'd2;

    logic [1:0]                 state;
    logic                       active;
    logic                       writeDone;
    debugLinkPkg::responseReq_t held;

    assign reqReady  = !active;
    assign outValid  = active;
    assign writeDone = outValid && outReady;

    always_comb begin
        case (state)
            SendLength:   outData = {6'd0, held.len};
            SendPayload0: outData = held.payload0;
            default:      outData = held.payload1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= SendLength;
            active <= 1'b0;
        end else if (!active) begin
            if (reqValid) active <= 1'b1;
            state <= SendLength;
        end else if (writeDone) begin
            case (state)
                SendLength: state <= SendPayload0;
                SendPayload0: begin
                    if (held.len == 2'd2) begin
                        state <= SendPayload1;
                    end else begin
                        active <= 1'b0;
                        state  <= SendLength;
                    end
                end
                default: begin
                    active <= 1'b0;
                    state  <= SendLength;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid && reqReady) held <= req;
    end

endmodule

// File: design/commandHandler.sv
`timescale 1ns/1ns
`include "debugLink_settings.svh"

module commandHandler (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [7:0]                 cmdData,
    input  logic                       cmdValid,
    output logic                       cmdPop,
    output debugLinkPkg::responseReq_t req,
    output logic                       reqValid,
    input  logic                       reqReady,
    output logic [3:0]                 led
);
    logic [7:0] cmdCount;
    logic [7:0] countNext;
    logic       isNop;

    // One command in flight at a time
    assign cmdPop    = cmdValid && !reqValid;
    assign isNop     = (cmdData == `DEBUG_CMD_NOP);
    // Status reply counts itself
    assign countNext = cmdCount + 8'd1;

    // ==================================================================
    // LED register, command count and request handshake
    // ==================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            led      <= '0;
            cmdCount <= '0;
            reqValid <= 1'b0;
        end else begin
            if (reqValid && reqReady) reqValid <= 1'b0;
            if (cmdPop && !isNop) begin
                cmdCount <= countNext;
                reqValid <= 1'b1;
                if (cmdData == `DEBUG_CMD_LED_OFF) led[0] <= 1'b0;
                if (cmdData == `DEBUG_CMD_LED_ON) led[0] <= 1'b1;
            end
        end
    end

    // ==================================================================
    // Response contents
    // ==================================================================
    always_ff @(posedge clk) begin
        if (cmdPop) begin
            case (cmdData)
                `DEBUG_CMD_LED_OFF,
                `DEBUG_CMD_LED_ON: begin
                    // Echo the opcode
                    req.len      <= 2'd1;
                    req.payload0 <= cmdData;
                    req.payload1 <= 8'h00;
                end
                `DEBUG_CMD_READ_STATUS: begin
                    req.len      <= 2'd2;
                    req.payload0 <= {4'b0000, led};
                    req.payload1 <= countNext;
                end
                default: begin
                    // Unknown opcode; a Nop also lands here but raises no request
                    req.len      <= 2'd1;
                    req.payload0 <= `DEBUG_REPLY_ERROR;
                    req.payload1 <= 8'h00;
                end
            endcase
        end
    end

endmodule

// File: design/serialReceiver.sv
`timescale 1ns/1ns
`include "debugLink_settings.svh"

module serialReceiver (
    input  logic                      clk,
    input  logic                      rst,
    input  debugLinkPkg::serialPins_t pins,
    output debugLinkPkg::serialEdge_t pinEvent,
    output logic [7:0]                cmdData,
    output logic                      cmdValid
);
    localparam int Stages = `DEBUG_SYNC_STAGES;

    debugLinkPkg::serialPins_t [Stages-1:0] syncPins;
    debugLinkPkg::serialPins_t              pinsNow;
    logic                                   prevClk;
    logic                                   rawRise;
    logic [2:0]                             bitCount;
    logic [6:0]                             shiftReg;

    // ==================================================================
    // Pin synchronizer and edge detect
    // ==================================================================
    assign pinsNow = syncPins[Stages-1];
    assign rawRise = pinsNow.debugClk && !prevClk && pinsNow.debugCs;

    always_ff @(posedge clk) begin
        if (rst) begin
            syncPins <= '0;
            prevClk  <= 1'b0;
            pinEvent <= '0;
        end else begin
            syncPins          <= {syncPins[Stages-2:0], pins};
            prevClk           <= pinsNow.debugClk;
            pinEvent.rise     <= rawRise;
            // Counter still holds the previous edge's update here
            pinEvent.boundary <= rawRise && (bitCount == 3'd0);
            pinEvent.data     <= pinsNow.debugDi;
        end
    end

    // ==================================================================
    // Bit counter and command shift register
    // ==================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            bitCount <= '0;
            cmdValid <= 1'b0;
        end else begin
            cmdValid <= 1'b0;
            if (!pinsNow.debugCs) begin
                bitCount <= '0;
            end else if (pinEvent.rise) begin
                bitCount <= bitCount + 1'b1;
                // Eighth bit completes the byte
                if (bitCount == 3'd7) cmdValid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pinEvent.rise) begin
            shiftReg <= {shiftReg[5:0], pinEvent.data};
            cmdData  <= {shiftReg, pinEvent.data};
        end
    end

endmodule

// File: design/byteFifo.sv
`timescale 1ns/1ns

module byteFifo #(
    parameter int Depth = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] writeData,
    input  logic       writeValid,
    output logic       writeReady,
    output logic [7:0] readData,
    output logic       readValid,
    input  logic       readPop
);
    localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CountWidth = $clog2(Depth + 1);

    logic [7:0]            mem [Depth];
    logic [PtrWidth-1:0]   writePtr;
    logic [PtrWidth-1:0]   readPtr;
    logic [CountWidth-1:0] count;
    logic                  doWrite;
    logic                  doRead;

    // Wraps at Depth, so Depth need not be a power of two
    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign writeReady = (count != CountWidth'(Depth));
    assign readValid  = (count != '0);
    assign doWrite    = writeValid && writeReady;
    assign doRead     = readPop && readValid;

    // Head is visible the cycle after it was written
    assign readData = mem[readPtr];

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[writePtr] <= writeData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr  <= '0;
            count    <= '0;
        end else begin
            if (doWrite) writePtr <= nextPtr(writePtr);
            if (doRead) readPtr <= nextPtr(readPtr);
            case ({doWrite, doRead})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: design/debugLinkPkg.sv
package debugLinkPkg;

    // ==================================================================
    // Serial port pins as seen from the chip
    // ==================================================================
    typedef struct packed {
        logic debugClk;
        logic debugCs;
        logic debugDi;
    } serialPins_t;

    // Synchronized view of one debugClk rising edge
    typedef struct packed {
        // One-cycle pulse per rising edge while debugCs is high
        logic rise;
        // Edge carries the first bit of a byte
        logic boundary;
        logic data;
    } serialEdge_t;

    // ==================================================================
    // Response request from the handler to the framer
    // ==================================================================
    typedef struct packed {
        // Payload byte count, 1 or 2
        logic [1:0] len;
        // Sent first
        logic [7:0] payload0;
        // Only sent when len is 2
        logic [7:0] payload1;
    } responseReq_t;

endpackage

// File: include/debugLink_settings.svh
`ifndef DEBUGLINK_SETTINGS_SVH
`define DEBUGLINK_SETTINGS_SVH

// Entries in each byte FIFO
`define DEBUG_FIFO_DEPTH 8

// At least 2 flip-flops in the pin synchronizer
`define DEBUG_SYNC_STAGES 2

// Host command opcodes and the reply to an unknown command
`define DEBUG_CMD_NOP         8'h00
`define DEBUG_CMD_LED_OFF     8'h80
`define DEBUG_CMD_LED_ON      8'h81
`define DEBUG_CMD_READ_STATUS 8'h82
`define DEBUG_REPLY_ERROR     8'hFF

`endif
